// ==== wbPkg.sv ====
//////////////////////////////
// shared types for the MIPS32 writeback stage.
// bus words are fixed at 32 bits, so DATA_W must stay 32.
// NOLOAD must keep the all-zero encoding, which flush relies on.
//////////////////////////////
`default_nettype none

package wbPkg;

    // load kinds handled in writeback.
    typedef enum logic [2:0] {
        NOLOAD = 3'd0,
        LB     = 3'd1,
        LBU    = 3'd2,
        LH     = 3'd3,
        LHU    = 3'd4,
        LW     = 3'd5,
        LWL    = 3'd6,
        LWR    = 3'd7
    } LoadType;

    // one enable per destination.
    typedef struct packed {
        logic rfWr;  // general register file.
        logic hiWr;
        logic loWr;
    } RegsWrType;

    // result comes from memory, any other code takes the earlier result.
    localparam logic [1:0] WBSEL_LOAD = 2'b11;

    // bundle delivered by the second memory stage.
    typedef struct packed {
        logic [31:0] aluOut;      // load address.
        LoadType     loadType;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [1:0]  wbSel;
        logic [4:0]  dst;
        logic [31:0] dmOut;       // raw memory word.
        logic [31:0] outB;        // old rt value, needed by LWL/LWR.
        RegsWrType   regsWrType;
        logic [31:0] result;      // earlier-stage value.
    } Mem2WbBus;

    // lane plan produced by the load decoder.
    typedef struct packed {
        logic [1:0] laneIdx;     // byte index, or half index in bit 0.
        logic       isHalf;
        logic       isByte;
        logic       signExt;
        logic       mergeLeft;   // LWL.
        logic       mergeRight;  // LWR.
        logic [1:0] shiftBytes;
    } LanePlan;

    // the memory word seen as bytes or as halfwords.
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } LoadWord;

endpackage : wbPkg

`default_nettype wire

// ==== wbStageReg.sv ====
//////////////////////////////
// writeback pipeline register, one item in flight.
// reset and flush load all-zero, flush wins over wr.
// DATA_W has to match the 32-bit bus words.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module wbStageReg import wbPkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     flush,
    input  logic     wr,
    input  Mem2WbBus d,
    output Mem2WbBus q
);

    // the bus carries fixed 32-bit words, anything else cannot work.
    if (DATA_W != $bits(d.dmOut)) begin : gWidthCheck
        $error("wbStageReg: DATA_W does not match the MEM2 bus word width");
    end

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            q <= '0;  // clears write types, loadType becomes NOLOAD.
        end else if (wr) begin
            q <= d;
        end
        // wr low holds the stage.
    end

endmodule : wbStageReg

`default_nettype wire

// ==== loadLaneDecode.sv ====
//////////////////////////////
// load lane planning, MIPS little-endian.
// halfword loads ignore offset bit 0, a misaligned
// access is expected to trap before writeback.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module loadLaneDecode import wbPkg::*; (
    input  LoadType    loadType,
    input  logic [1:0] offset,
    output LanePlan    plan
);

    always_comb begin
        plan = '0;  // LW and NOLOAD pass the word untouched.
        case (loadType)
            LB: begin
                plan.isByte  = 1'b1;
                plan.signExt = 1'b1;
                plan.laneIdx = offset;
            end
            LBU: begin
                plan.isByte  = 1'b1;
                plan.laneIdx = offset;
            end
            LH: begin
                plan.isHalf  = 1'b1;
                plan.signExt = 1'b1;
                plan.laneIdx = {1'b0, offset[1]};
            end
            LHU: begin
                plan.isHalf  = 1'b1;
                plan.laneIdx = {1'b0, offset[1]};
            end
            LWL: begin
                // bytes 0..offset go to the top of rt.
                plan.mergeLeft  = 1'b1;
                plan.shiftBytes = 2'd3 - offset;
            end
            LWR: begin
                // bytes offset..3 go to the bottom of rt.
                plan.mergeRight = 1'b1;
                plan.shiftBytes = offset;
            end
            default: begin
                plan = '0;
            end
        endcase
    end

endmodule : loadLaneDecode

`default_nettype wire

// ==== loadAlignExtend.sv ====
//////////////////////////////
// extracts, merges and extends load data from the lane plan.
// the lane view is a 32-bit word, so DATA_W is 32 here.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module loadAlignExtend import wbPkg::*; #(
    parameter int DATA_W = 32
) (
    input  LanePlan             plan,
    input  logic [DATA_W-1:0]   dmOut,
    input  logic [DATA_W-1:0]   outB,
    output logic [DATA_W-1:0]   loadData
);

    localparam int NBYTES = DATA_W / 8;

    LoadWord           memWord;
    logic [7:0]        laneByte;
    logic [15:0]       laneHalf;
    logic [4:0]        shiftBits;
    logic [DATA_W-1:0] leftShifted;
    logic [DATA_W-1:0] rightShifted;
    logic [DATA_W-1:0] mergedWord;

    assign memWord  = dmOut;
    assign laneByte = memWord.bytes[plan.laneIdx];
    assign laneHalf = memWord.halves[plan.laneIdx[0]];

    // byte shift turned into a bit shift.
    assign shiftBits    = {plan.shiftBytes, 3'b000};
    assign leftShifted  = dmOut << shiftBits;   // LWL moves low bytes up.
    assign rightShifted = dmOut >> shiftBits;   // LWR moves high bytes down.

    // bytes not covered by memory keep the old rt value.
    always_comb begin
        mergedWord = outB;
        for (int i = 0; i < NBYTES; i++) begin
            if (plan.mergeLeft && i >= int'(plan.shiftBytes)) begin
                mergedWord[8*i +: 8] = leftShifted[8*i +: 8];
            end
            if (plan.mergeRight && i + int'(plan.shiftBytes) < NBYTES) begin
                mergedWord[8*i +: 8] = rightShifted[8*i +: 8];
            end
        end
    end

    always_comb begin
        if (plan.isByte) begin
            loadData = {{(DATA_W-8){plan.signExt & laneByte[7]}}, laneByte};
        end else if (plan.isHalf) begin
            loadData = {{(DATA_W-16){plan.signExt & laneHalf[15]}}, laneHalf};
        end else if (plan.mergeLeft || plan.mergeRight) begin
            loadData = mergedWord;
        end else begin
            loadData = dmOut;  // full word, or no load at all.
        end
    end

endmodule : loadAlignExtend

`default_nettype wire

// ==== wbResultSelect.sv ====
//////////////////////////////
// final writeback value and write gating.
// disWr is a level from the data cache and acts at once.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module wbResultSelect import wbPkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic [1:0]        wbSel,
    input  logic [DATA_W-1:0] priorResult,
    input  logic [DATA_W-1:0] loadData,
    input  RegsWrType         regsWr,
    input  logic              disWr,
    output logic [DATA_W-1:0] result,
    output RegsWrType         finalWr
);

    // only the load code picks memory data.
    assign result = (wbSel == WBSEL_LOAD) ? loadData : priorResult;

    // a stalled cache must not let writeback reach the register files.
    assign finalWr = disWr ? '0 : regsWr;

endmodule : wbResultSelect

`default_nettype wire

// ==== wbTop.sv ====
//////////////////////////////
// writeback stage, one cycle from m2wb to the outputs.
// flush, wr and disWr are plain levels, no handshake.
// DATA_W must be 32 to match the bus.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module wbTop import wbPkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              wbFlush,
    input  logic              wbWr,
    input  logic              wbDisWr,
    input  Mem2WbBus          m2wb,
    output logic [DATA_W-1:0] wbResult,
    output logic [4:0]        wbDst,
    output RegsWrType         wbFinalWr,
    output RegsWrType         wbRegsWrType,
    output logic [31:0]       wbPc
);

    Mem2WbBus          stageQ;
    LanePlan           plan;
    logic [DATA_W-1:0] loadResult;

    wbStageReg #(.DATA_W(DATA_W)) u_wbStageReg (
        .clk   (clk),
        .rstN  (rstN),
        .flush (wbFlush),
        .wr    (wbWr),
        .d     (m2wb),
        .q     (stageQ)
    );

    loadLaneDecode u_loadLaneDecode (
        .loadType (stageQ.loadType),
        .offset   (stageQ.aluOut[1:0]),  // byte offset inside the word.
        .plan     (plan)
    );

    loadAlignExtend #(.DATA_W(DATA_W)) u_loadAlignExtend (
        .plan     (plan),
        .dmOut    (stageQ.dmOut),
        .outB     (stageQ.outB),
        .loadData (loadResult)
    );

    wbResultSelect #(.DATA_W(DATA_W)) u_wbResultSelect (
        .wbSel       (stageQ.wbSel),
        .priorResult (stageQ.result),
        .loadData    (loadResult),
        .regsWr      (stageQ.regsWrType),
        .disWr       (wbDisWr),
        .result      (wbResult),
        .finalWr     (wbFinalWr)
    );

    // latched fields that leave the stage unchanged.
    assign wbDst        = stageQ.dst;
    assign wbPc         = stageQ.pc;
    assign wbRegsWrType = stageQ.regsWrType;  // ungated, unlike wbFinalWr.

endmodule : wbTop

`default_nettype wire

// ==== wb_checker.sv ====
//////////////////////////////
// assertions bound into wbTop.
// sampled on the rising clock, inputs settle before it.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module wbChecker import wbPkg::*; #(
    parameter int DATA_W = 32
) (
    input logic              clk,
    input logic              rstN,
    input logic              wbFlush,
    input logic              wbWr,
    input logic              wbDisWr,
    input logic [DATA_W-1:0] wbResult,
    input logic [4:0]        wbDst,
    input RegsWrType         wbFinalWr,
    input RegsWrType         wbRegsWrType,
    input logic [31:0]       wbPc
);

    int assertFails = 0;  // read by the testbench at the end.

    // no destination is written while the cache holds writes off.
    disWrGates: assert property (@(posedge clk) wbDisWr |-> wbFinalWr == '0)
        else begin
            $error("finalWr is not zero while disWr is high");
            assertFails++;
        end

    flushClears: assert property (@(posedge clk) wbFlush |=> wbRegsWrType == '0)
        else begin
            $error("regsWrType is not zero the cycle after a flush");
            assertFails++;
        end

    // a stall without flush keeps the latched item.
    stallHolds: assert property (@(posedge clk) disable iff (!rstN)
        (!wbWr && !wbFlush) |=> $stable(wbResult) && $stable(wbDst) && $stable(wbPc)
                                && $stable(wbRegsWrType))
        else begin
            $error("outputs changed while the stage was stalled");
            assertFails++;
        end

endmodule : wbChecker

`default_nettype wire

// ==== wbTb.sv ====
//////////////////////////////
// testbench for the writeback stage, DATA_W fixed at 32.
// one row per cycle, checked at the falling edge after.
// random rows use a fixed seed.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module wbTb import wbPkg::*; ();

    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 2;
    localparam int          RANDOM_ROWS  = 8;
    localparam logic [31:0] DM_WORD      = 32'h8a7b_c6d5;
    localparam logic [31:0] RT_WORD      = 32'h1122_3344;

    typedef struct packed {
        logic        flush;
        logic        wr;
        logic        disWr;
        Mem2WbBus    bus;
        logic [31:0] expResult;
        RegsWrType   expFinalWr;
        RegsWrType   expRegsWr;
        logic [4:0]  expDst;
        logic [31:0] expPc;
    } TestRow;

    logic        clk;
    logic        rstN;
    logic        wbFlush;
    logic        wbWr;
    logic        wbDisWr;
    Mem2WbBus    m2wb;
    logic [31:0] wbResult;
    logic [4:0]  wbDst;
    RegsWrType   wbFinalWr;
    RegsWrType   wbRegsWrType;
    logic [31:0] wbPc;

    TestRow rows[$];
    string  rowNames[$];
    int     errors     = 0;
    bit     tableReady = 1'b0;

    wbTop #(.DATA_W(32)) u_wbTop (
        .clk          (clk),
        .rstN         (rstN),
        .wbFlush      (wbFlush),
        .wbWr         (wbWr),
        .wbDisWr      (wbDisWr),
        .m2wb         (m2wb),
        .wbResult     (wbResult),
        .wbDst        (wbDst),
        .wbFinalWr    (wbFinalWr),
        .wbRegsWrType (wbRegsWrType),
        .wbPc         (wbPc)
    );

    bind wbTop wbChecker #(.DATA_W(DATA_W)) u_wbChecker (
        .clk          (clk),
        .rstN         (rstN),
        .wbFlush      (wbFlush),
        .wbWr         (wbWr),
        .wbDisWr      (wbDisWr),
        .wbResult     (wbResult),
        .wbDst        (wbDst),
        .wbFinalWr    (wbFinalWr),
        .wbRegsWrType (wbRegsWrType),
        .wbPc         (wbPc)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic Mem2WbBus makeBus(input logic [31:0] addr, input LoadType lt,
                                         input logic [1:0] sel, input logic [4:0] dst,
                                         input logic [31:0] dm, input logic [31:0] rt,
                                         input RegsWrType regsWr, input logic [31:0] prior,
                                         input logic [31:0] pc);
        Mem2WbBus b;
        b.aluOut     = addr;
        b.loadType   = lt;
        b.pc         = pc;
        b.instr      = ~pc;  // writeback never looks at it.
        b.wbSel      = sel;
        b.dst        = dst;
        b.dmOut      = dm;
        b.outB       = rt;
        b.regsWrType = regsWr;
        b.result     = prior;
        return b;
    endfunction

    // little-endian lane rules, one byte at a time.
    function automatic logic [31:0] refLoad(input LoadType lt, input logic [1:0] off,
                                            input logic [31:0] dm, input logic [31:0] rt);
        logic [7:0] m [4];
        logic [7:0] r [4];
        logic [1:0] lo;
        logic [1:0] hi;
        for (int k = 0; k < 4; k++) begin
            m[k] = dm[8*k +: 8];
            r[k] = rt[8*k +: 8];
        end
        lo = {off[1], 1'b0};
        hi = {off[1], 1'b1};
        case (lt)
            LB:      return {{24{m[off][7]}}, m[off]};
            LBU:     return {24'h0, m[off]};
            LH:      return {{16{m[hi][7]}}, m[hi], m[lo]};
            LHU:     return {16'h0, m[hi], m[lo]};
            LWL: begin
                for (int k = 0; k <= int'(off); k++) r[3 - int'(off) + k] = m[k];
                return {r[3], r[2], r[1], r[0]};
            end
            LWR: begin
                for (int k = int'(off); k < 4; k++) r[k - int'(off)] = m[k];
                return {r[3], r[2], r[1], r[0]};
            end
            default: return dm;
        endcase
    endfunction

    task automatic addRow(input string name, input logic flush, input logic wr,
                          input logic disWr, input Mem2WbBus bus, input logic [31:0] expResult,
                          input RegsWrType expFinalWr, input RegsWrType expRegsWr,
                          input logic [4:0] expDst, input logic [31:0] expPc);
        TestRow row;
        row.flush      = flush;
        row.wr         = wr;
        row.disWr      = disWr;
        row.bus        = bus;
        row.expResult  = expResult;
        row.expFinalWr = expFinalWr;
        row.expRegsWr  = expRegsWr;
        row.expDst     = expDst;
        row.expPc      = expPc;
        rows.push_back(row);
        rowNames.push_back(name);
    endtask

    task automatic buildTable();
        Mem2WbBus    bus;
        LoadType     lt;
        logic [1:0]  off;
        logic [1:0]  sel;
        logic [31:0] exp;
        RegsWrType   wrType;
        bus = makeBus(32'h0, NOLOAD, 2'b01, 5'd7, DM_WORD, RT_WORD, 3'b111, 32'h5555_aaaa,
                      32'h0040_0000);
        addRow("flushOverWr", 1'b1, 1'b1, 1'b0, bus, 32'h0, 3'b000, 3'b000, 5'd0, 32'h0);
        bus = makeBus(32'h0, NOLOAD, 2'b01, 5'd9, DM_WORD, RT_WORD, 3'b100, 32'hdead_beef,
                      32'h0040_0010);
        addRow("aluPass", 1'b0, 1'b1, 1'b0, bus, 32'hdead_beef, 3'b100, 3'b100, 5'd9,
               32'h0040_0010);
        // new inputs with wr low must not reach the outputs.
        bus = makeBus(32'h3, LB, 2'b11, 5'd30, ~DM_WORD, ~RT_WORD, 3'b011, 32'h0, 32'h0040_0fff);
        addRow("stallHold", 1'b0, 1'b0, 1'b0, bus, 32'hdead_beef, 3'b100, 3'b100, 5'd9,
               32'h0040_0010);
        bus = makeBus(32'h0, NOLOAD, 2'b10, 5'd0, DM_WORD, RT_WORD, 3'b011, 32'h1234_5678,
                      32'h0040_0014);
        addRow("hiLoPass", 1'b0, 1'b1, 1'b0, bus, 32'h1234_5678, 3'b011, 3'b011, 5'd0,
               32'h0040_0014);
        for (int t = int'(LB); t <= int'(LWR); t++) begin
            for (int o = 0; o < 4; o++) begin
                lt  = LoadType'(t[2:0]);
                off = o[1:0];
                if ((lt == LH || lt == LHU) && off[0]) continue;  // halfwords stay aligned.
                bus = makeBus({30'h0000_4000, off}, lt, 2'b11, {t[2:0], off}, DM_WORD, RT_WORD,
                              3'b100, 32'hffff_0000, 32'h0040_1000 + 32'(16 * t + 4 * o));
                exp = refLoad(lt, off, DM_WORD, RT_WORD);
                addRow($sformatf("%s_off%0d", lt.name(), o), 1'b0, 1'b1, 1'b0, bus, exp,
                       3'b100, 3'b100, bus.dst, bus.pc);
            end
        end
        // gating follows disWr as a level.
        bus = makeBus(32'h0, NOLOAD, 2'b01, 5'd3, DM_WORD, RT_WORD, 3'b111, 32'hcafe_f00d,
                      32'h0040_2000);
        addRow("disWr", 1'b0, 1'b1, 1'b1, bus, 32'hcafe_f00d, 3'b000, 3'b111, 5'd3,
               32'h0040_2000);
        addRow("disWrRelease", 1'b0, 1'b0, 1'b0, bus, 32'hcafe_f00d, 3'b111, 3'b111, 5'd3,
               32'h0040_2000);
        for (int n = 0; n < RANDOM_ROWS; n++) begin
            lt     = LoadType'(3'($urandom()));
            off    = 2'($urandom());
            sel    = 2'($urandom());
            wrType = RegsWrType'(3'($urandom()));
            if (lt == LH || lt == LHU) off[0] = 1'b0;
            bus = makeBus({30'($urandom()), off}, lt, sel, 5'($urandom()), $urandom(),
                          $urandom(), wrType, $urandom(), $urandom());
            exp = (sel == 2'b11) ? refLoad(lt, off, bus.dmOut, bus.outB) : bus.result;
            addRow($sformatf("random%0d", n), 1'b0, 1'b1, 1'b0, bus, exp, wrType, wrType,
                   bus.dst, bus.pc);
        end
        bus = makeBus(32'h2, LWL, 2'b11, 5'd17, DM_WORD, RT_WORD, 3'b111, 32'h0, 32'h0040_3000);
        addRow("flushLate", 1'b1, 1'b1, 1'b0, bus, 32'h0, 3'b000, 3'b000, 5'd0, 32'h0);
        addRow("holdFlushed", 1'b0, 1'b0, 1'b0, bus, 32'h0, 3'b000, 3'b000, 5'd0, 32'h0);
    endtask

    task automatic checkValue(input string name, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s %s: expected %h, actual %h", name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic checkRow(input int i);
        TestRow r;
        r = rows[i];
        checkValue(rowNames[i], "result", r.expResult, wbResult);
        checkValue(rowNames[i], "finalWr", {29'h0, r.expFinalWr}, {29'h0, wbFinalWr});
        checkValue(rowNames[i], "regsWrType", {29'h0, r.expRegsWr}, {29'h0, wbRegsWrType});
        checkValue(rowNames[i], "dst", {27'h0, r.expDst}, {27'h0, wbDst});
        checkValue(rowNames[i], "pc", r.expPc, wbPc);
    endtask

    task automatic applyRow(input int i);
        wbFlush = rows[i].flush;
        wbWr    = rows[i].wr;
        wbDisWr = rows[i].disWr;
        m2wb    = rows[i].bus;
    endtask

    initial begin
        int seedDummy;
        int assertFails;
        seedDummy = $urandom(32'h8f5c_9705);
        rstN    = 1'b0;
        wbFlush = 1'b0;
        wbWr    = 1'b1;  // reset must win over a pending write.
        wbDisWr = 1'b0;
        m2wb    = makeBus(32'h1, LB, 2'b11, 5'd31, DM_WORD, RT_WORD, 3'b111, 32'h0, 32'h0040_0fff);
        buildTable();
        tableReady = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        checkValue("reset", "finalWr", 32'h0, {29'h0, wbFinalWr});
        checkValue("reset", "regsWrType", 32'h0, {29'h0, wbRegsWrType});
        checkValue("reset", "dst", 32'h0, {27'h0, wbDst});
        checkValue("reset", "pc", 32'h0, wbPc);
        rstN = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            if (i > 0) begin
                @(negedge clk);
                checkRow(i - 1);
            end
            applyRow(i);
        end
        @(negedge clk);
        checkRow(rows.size() - 1);
        assertFails = u_wbTop.u_wbChecker.assertFails;
        $display("checks done: %0d errors, %0d assertion failures", errors, assertFails);
        if (errors == 0 && assertFails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog sized from the table.
    initial begin
        wait (tableReady);
        #((rows.size() + RESET_CYCLES + 10) * CLK_PERIOD);
        $display("timeout: the run did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule : wbTb

`default_nettype wire

// ==== sources.f ====
wbPkg.sv
wbStageReg.sv
loadLaneDecode.sv
loadAlignExtend.sv
wbResultSelect.sv
wbTop.sv
wb_checker.sv
wbTb.sv

// ==== Makefile ====
# Verilator flow for the writeback stage testbench.
TOP := wbTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

# the run passes only if the log holds the pass line.
sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o simv
	./obj_dir/simv +verilator+error+limit+1000 | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
